// File: design/hk_params.svh
/* Fixed IDs and reset values of the housekeeping registers, included by the
   register file and by anything that models it */
`ifndef HK_PARAMS_SVH
`define HK_PARAMS_SVH

// ------------------------------
// Identification
// ------------------------------

// Manufacturer ID, 12 bits, split over registers 1 and 2
`define HK_MFGR_ID       12'h456
// Product ID, register 3
`define HK_PROD_ID       8'h10

// ------------------------------
// PLL reset values
// ------------------------------

// Near the slowest DCO rate; bit 12 must be clear for a clean startup
`define HK_PLL_TRIM_RST  26'h3FFEFFF
// Divide setting out of reset
`define HK_PLL_DIV_RST   5'd4
// Output select out of reset
`define HK_PLL_SEL_RST   3'd0
// DCO free-running from power-up
`define HK_DCO_ENA_RST   1'b1
// Start in bypass, PLL not in the clock path
`define HK_BYPASS_RST    1'b1

`endif

// File: design/hk_pkg.sv
/* Shared types for the housekeeping SPI: slave phases, register map and the bundles
   passed between the slave, the register file and the pass-through steering */
`default_nettype none

package hk_pkg;

    // Slave protocol phases
    typedef enum logic [2:0] {
        COMMAND  = 3'b000,
        ADDRESS  = 3'b001,
        DATA     = 3'b010,
        USERPASS = 3'b100,
        MGMTPASS = 3'b101
    } hk_state_e;

    // ------------------------------
    // Register map
    // ------------------------------
    typedef enum logic [7:0] {
        REG_STATUS  = 8'h00,
        REG_MFGR_HI = 8'h01,
        REG_MFGR_LO = 8'h02,
        REG_PROD_ID = 8'h03,
        REG_MASK_3  = 8'h04,
        REG_MASK_2  = 8'h05,
        REG_MASK_1  = 8'h06,
        REG_MASK_0  = 8'h07,
        REG_DCO_ENA = 8'h08,
        REG_BYPASS  = 8'h09,
        REG_IRQ     = 8'h0A,
        REG_RESET   = 8'h0B,
        REG_TRAP    = 8'h0C,
        REG_TRIM_0  = 8'h0D,
        REG_TRIM_1  = 8'h0E,
        REG_TRIM_2  = 8'h0F,
        REG_TRIM_3  = 8'h10,
        REG_PLL_SEL = 8'h11,
        REG_PLL_DIV = 8'h12
    } hk_reg_addr_e;

    // Register access from the slave
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] wdata;
        logic       wrstb;
    } reg_bus_t;

    // PLL controls as seen by the clock block
    typedef struct packed {
        logic        dco_ena;
        logic        bypass;
        logic [25:0] trim;
        logic [2:0]  sel;
        logic [4:0]  div;
    } pll_cfg_t;

    // Pass-through mode flags from the command decoder
    typedef struct packed {
        logic mgmt;
        logic mgmt_delay;
        logic user;
        logic user_delay;
        logic force_reset;
    } pass_ctl_t;

    // Outgoing pins of one SPI flash
    typedef struct packed {
        logic csb;
        logic sck;
        logic sdi;
    } flash_port_t;

endpackage

`default_nettype wire

// File: design/hk_spi_slave.sv
/* SPI slave protocol engine: command, address and data phases, write strobe,
   read shift-out and pass-through mode detection, clocked by SCK only */
`timescale 1ns/1ps
`default_nettype none

module hk_spi_slave import hk_pkg::*; (
    input  logic       RSTB,
    input  logic       SCK,
    input  logic       SDI,
    input  logic       CSB,
    input  logic [7:0] rdata,
    output reg_bus_t   bus,
    output pass_ctl_t  pass,
    output logic       loc_sdo,
    output logic       sdo_enb
);

    hk_state_e  state;
    logic [2:0] count;
    logic [2:0] fixed;
    logic       writemode;
    logic       readmode;
    logic [6:0] predata;
    logic [7:0] addr;
    logic [7:0] ldata;
    logic       wrstb;
    logic       pre_mgmt;
    logic       pre_user;
    logic       mgmt_on;
    logic       mgmt_delay;
    logic       user_on;
    logic       user_delay;
    logic       csb_reset;

    // Frame ends or chip reset both restart the protocol
    assign csb_reset = CSB | ~RSTB;

    // Write data is 7 shifted bits plus the live SDI bit
    assign bus = '{addr: addr, wdata: {predata, SDI}, wrstb: wrstb};

    assign loc_sdo = ldata[7];

    // Core reset requested as soon as the mgmt pass bit is seen
    assign pass = '{
        mgmt:        mgmt_on,
        mgmt_delay:  mgmt_delay,
        user:        user_on,
        user_delay:  user_delay,
        force_reset: mgmt_delay | pre_mgmt
    };

    // ------------------------------
    // Falling edge: strobe and SDO
    // ------------------------------
    always_ff @(negedge SCK or posedge csb_reset) begin
        if (csb_reset) begin
            wrstb   <= 1'b0;
            ldata   <= 8'h00;
            sdo_enb <= 1'b1;
        end else begin
            case (state)
                DATA: begin
                    sdo_enb <= ~readmode;
                    // Load at byte start, so a read/write returns the old value
                    if (readmode) begin
                        if (count == 3'd0) begin
                            ldata <= rdata;
                        end else begin
                            ldata <= {ldata[6:0], 1'b0};
                        end
                    end
                    // Strobe ahead of the 8th bit, register loads on its rising edge
                    wrstb <= writemode && (count == 3'd7);
                end
                MGMTPASS, USERPASS: begin
                    // Flash drives SDO through the top-level mux
                    wrstb   <= 1'b0;
                    sdo_enb <= 1'b0;
                end
                default: begin
                    wrstb   <= 1'b0;
                    sdo_enb <= 1'b1;
                end
            endcase
        end
    end

    // ------------------------------
    // Rising edge: phase tracking
    // ------------------------------
    always_ff @(posedge SCK or posedge csb_reset) begin
        if (csb_reset) begin
            state      <= COMMAND;
            count      <= 3'd0;
            fixed      <= 3'd0;
            writemode  <= 1'b0;
            readmode   <= 1'b0;
            predata    <= 7'h00;
            addr       <= 8'h00;
            pre_mgmt   <= 1'b0;
            pre_user   <= 1'b0;
            mgmt_on    <= 1'b0;
            mgmt_delay <= 1'b0;
            user_on    <= 1'b0;
            user_delay <= 1'b0;
        end else begin
            case (state)
                COMMAND: begin
                    count <= count + 3'd1;
                    case (count)
                        3'd0: writemode <= SDI;
                        3'd1: readmode  <= SDI;
                        // Fixed byte count, bits 5..3
                        3'd2, 3'd3, 3'd4: fixed <= {fixed[1:0], SDI};
                        3'd5: pre_mgmt <= SDI;
                        3'd6: begin
                            pre_user   <= SDI;
                            mgmt_delay <= pre_mgmt;
                        end
                        default: begin
                            user_delay <= pre_user;
                            if (pre_mgmt) begin
                                state    <= MGMTPASS;
                                pre_mgmt <= 1'b0;
                            end else if (pre_user) begin
                                state    <= USERPASS;
                                pre_user <= 1'b0;
                            end else begin
                                state <= ADDRESS;
                            end
                        end
                    endcase
                end
                ADDRESS: begin
                    count <= count + 3'd1;
                    addr  <= {addr[6:0], SDI};
                    if (count == 3'd7) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    count   <= count + 3'd1;
                    predata <= {predata[5:0], SDI};
                    if (count == 3'd7) begin
                        // Last byte of a fixed transfer, wait for a new command
                        if (fixed == 3'd1) begin
                            state <= COMMAND;
                        end else begin
                            if (fixed != 3'd0) begin
                                fixed <= fixed - 3'd1;
                            end
                            addr <= addr + 8'd1;
                        end
                    end
                end
                MGMTPASS: mgmt_on <= 1'b1;
                USERPASS: user_on <= 1'b1;
                default: state <= COMMAND;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/hk_regfile.sv
/* Housekeeping register map: control registers written on the slave strobe and a
   combinational read mux over the full address space */
`timescale 1ns/1ps
`default_nettype none
`include "hk_params.svh"

module hk_regfile import hk_pkg::*; (
    input  logic        SCK,
    input  logic        RSTB,
    input  reg_bus_t    bus,
    input  logic        trap,
    input  logic [31:0] mask_rev_in,
    input  logic        reset_out,
    output logic [7:0]  rdata,
    output pll_cfg_t    pll,
    output logic        irq,
    output logic        reset_reg
);

    localparam logic [11:0] MFGR_ID = `HK_MFGR_ID;
    localparam logic [7:0]  PROD_ID = `HK_PROD_ID;

    // ------------------------------
    // Writable registers
    // ------------------------------
    always_ff @(posedge SCK or negedge RSTB) begin
        if (!RSTB) begin
            pll.dco_ena <= `HK_DCO_ENA_RST;
            pll.bypass  <= `HK_BYPASS_RST;
            pll.trim    <= `HK_PLL_TRIM_RST;
            pll.sel     <= `HK_PLL_SEL_RST;
            pll.div     <= `HK_PLL_DIV_RST;
            irq         <= 1'b0;
            reset_reg   <= 1'b0;
        end else if (bus.wrstb) begin
            // IDs, mask rev and trap are read only
            case (bus.addr)
                REG_DCO_ENA: pll.dco_ena       <= bus.wdata[0];
                REG_BYPASS:  pll.bypass        <= bus.wdata[0];
                REG_IRQ:     irq               <= bus.wdata[0];
                REG_RESET:   reset_reg         <= bus.wdata[0];
                REG_TRIM_0:  pll.trim[7:0]     <= bus.wdata;
                REG_TRIM_1:  pll.trim[15:8]    <= bus.wdata;
                REG_TRIM_2:  pll.trim[23:16]   <= bus.wdata;
                REG_TRIM_3:  pll.trim[25:24]   <= bus.wdata[1:0];
                REG_PLL_SEL: pll.sel           <= bus.wdata[2:0];
                REG_PLL_DIV: pll.div           <= bus.wdata[4:0];
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Read mux
    // ------------------------------
    always_comb begin
        case (bus.addr)
            REG_STATUS:  rdata = 8'h00;
            REG_MFGR_HI: rdata = {4'h0, MFGR_ID[11:8]};
            REG_MFGR_LO: rdata = MFGR_ID[7:0];
            REG_PROD_ID: rdata = PROD_ID;
            // Mask revision, most significant byte first
            REG_MASK_3:  rdata = mask_rev_in[31:24];
            REG_MASK_2:  rdata = mask_rev_in[23:16];
            REG_MASK_1:  rdata = mask_rev_in[15:8];
            REG_MASK_0:  rdata = mask_rev_in[7:0];
            REG_DCO_ENA: rdata = {7'h00, pll.dco_ena};
            REG_BYPASS:  rdata = {7'h00, pll.bypass};
            REG_IRQ:     rdata = {7'h00, irq};
            // Core reset as driven, pass-through request included
            REG_RESET:   rdata = {7'h00, reset_out};
            REG_TRAP:    rdata = {7'h00, trap};
            // Trim, low byte at the lower address
            REG_TRIM_0:  rdata = pll.trim[7:0];
            REG_TRIM_1:  rdata = pll.trim[15:8];
            REG_TRIM_2:  rdata = pll.trim[23:16];
            REG_TRIM_3:  rdata = {6'h00, pll.trim[25:24]};
            REG_PLL_SEL: rdata = {5'h00, pll.sel};
            REG_PLL_DIV: rdata = {3'h0, pll.div};
            default:     rdata = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// File: design/hk_pass_thru.sv
/* Flash pass-through steering: routes SPI pins to the selected flash while the
   core is held in reset, and picks the SDO source */
`timescale 1ns/1ps
`default_nettype none

module hk_pass_thru import hk_pkg::*; (
    input  logic        SCK,
    input  logic        SDI,
    input  pass_ctl_t   pass,
    input  logic        reset_reg,
    input  logic        loc_sdo,
    input  logic        mgmt_sdo,
    input  logic        user_sdo,
    output logic        SDO,
    output logic        reset,
    output logic        pass_thru_reset,
    output flash_port_t mgmt_flash,
    output flash_port_t user_flash
);

    // Pins of one flash, idle unless the core is in reset
    function automatic flash_port_t steer(input logic core_rst, input logic mode,
                                          input logic sel_delay, input logic sck_in,
                                          input logic sdi_in);
        flash_port_t port;
        port.csb = core_rst ? ~sel_delay : 1'b1;
        port.sck = core_rst & mode & sck_in;
        port.sdi = core_rst & mode & sdi_in;
        return port;
    endfunction

    assign pass_thru_reset = pass.force_reset;
    assign reset           = pass.force_reset | reset_reg;

    assign mgmt_flash = steer(reset, pass.mgmt, pass.mgmt_delay, SCK, SDI);
    assign user_flash = steer(reset, pass.user, pass.user_delay, SCK, SDI);

    // Active flash owns SDO, otherwise the slave shift register
    assign SDO = pass.mgmt ? mgmt_sdo :
                 pass.user ? user_sdo : loc_sdo;

endmodule

`default_nettype wire

// File: design/housekeeping_spi.sv
/* Housekeeping SPI top level: connects the SPI slave, the register file and the
   flash pass-through steering */
`timescale 1ns/1ps
`default_nettype none

module housekeeping_spi import hk_pkg::*; (
    input  logic        RSTB,
    input  logic        SCK,
    input  logic        SDI,
    input  logic        CSB,
    input  logic        trap,
    input  logic [31:0] mask_rev_in,
    input  logic        mgmt_sdo,
    input  logic        user_sdo,
    output logic        SDO,
    output logic        sdo_enb,
    output pll_cfg_t    pll,
    output logic        irq,
    output logic        reset,
    output flash_port_t mgmt_flash,
    output flash_port_t user_flash,
    output logic        pass_thru_reset
);

    reg_bus_t   bus;
    pass_ctl_t  pass;
    logic [7:0] rdata;
    logic       loc_sdo;
    logic       reset_reg;

    // Protocol engine
    hk_spi_slave u_slave (
        .RSTB    (RSTB),
        .SCK     (SCK),
        .SDI     (SDI),
        .CSB     (CSB),
        .rdata   (rdata),
        .bus     (bus),
        .pass    (pass),
        .loc_sdo (loc_sdo),
        .sdo_enb (sdo_enb)
    );

    // Register map, reads back the combined core reset
    hk_regfile u_regs (
        .SCK         (SCK),
        .RSTB        (RSTB),
        .bus         (bus),
        .trap        (trap),
        .mask_rev_in (mask_rev_in),
        .reset_out   (reset),
        .rdata       (rdata),
        .pll         (pll),
        .irq         (irq),
        .reset_reg   (reset_reg)
    );

    // Flash steering and SDO select
    hk_pass_thru u_pass (
        .SCK             (SCK),
        .SDI             (SDI),
        .pass            (pass),
        .reset_reg       (reset_reg),
        .loc_sdo         (loc_sdo),
        .mgmt_sdo        (mgmt_sdo),
        .user_sdo        (user_sdo),
        .SDO             (SDO),
        .reset           (reset),
        .pass_thru_reset (pass_thru_reset),
        .mgmt_flash      (mgmt_flash),
        .user_flash      (user_flash)
    );

endmodule

`default_nettype wire

// File: test/tb_housekeeping_spi.sv
/* Randomized self-checking testbench for the housekeeping SPI. It drives SPI frames,
   mirrors the register map in a model and checks readback, outputs and pass-through */
`timescale 1ns/1ps
`default_nettype none
`include "hk_params.svh"

module tb_housekeeping_spi import hk_pkg::*; ();

    localparam logic [11:0] MFGR_ID = `HK_MFGR_ID;

    logic        SCK = 1'b0;
    logic        RSTB;
    logic        SDI;
    logic        CSB;
    logic        trap;
    logic [31:0] mask_rev_in;
    logic        mgmt_sdo;
    logic        user_sdo;
    logic        SDO;
    logic        sdo_enb;
    pll_cfg_t    pll;
    logic        irq;
    logic        reset;
    flash_port_t mgmt_flash;
    flash_port_t user_flash;
    logic        pass_thru_reset;

    // Register model, one field per writable register
    logic        m_dco;
    logic        m_bypass;
    logic        m_irq;
    logic        m_rst;
    logic [25:0] m_trim;
    logic [2:0]  m_sel;
    logic [4:0]  m_div;

    int          checks;
    int          errors;
    int          timeouts;
    int          a;
    int          n;
    int          len;
    logic [31:0] r;

    housekeeping_spi uut (
        .RSTB            (RSTB),
        .SCK             (SCK),
        .SDI             (SDI),
        .CSB             (CSB),
        .trap            (trap),
        .mask_rev_in     (mask_rev_in),
        .mgmt_sdo        (mgmt_sdo),
        .user_sdo        (user_sdo),
        .SDO             (SDO),
        .sdo_enb         (sdo_enb),
        .pll             (pll),
        .irq             (irq),
        .reset           (reset),
        .mgmt_flash      (mgmt_flash),
        .user_flash      (user_flash),
        .pass_thru_reset (pass_thru_reset)
    );

    // 8 ns SPI clock, free running
    always #4 SCK = ~SCK;

    function automatic logic [7:0] rand_byte();
        logic [31:0] v;
        v = $urandom;
        return v[7:0];
    endfunction

    // Command byte: write, read, fixed count, mgmt pass, user pass, unused
    function automatic logic [7:0] make_cmd(input logic w, input logic rd, input logic [2:0] cnt,
                                            input logic mg, input logic us);
        return {w, rd, cnt, mg, us, 1'b0};
    endfunction

    // ------------------------------
    // Register model
    // ------------------------------
    function automatic logic [7:0] model_read(input logic [7:0] addr);
        case (addr)
            REG_MFGR_HI: return {4'h0, MFGR_ID[11:8]};
            REG_MFGR_LO: return MFGR_ID[7:0];
            REG_PROD_ID: return `HK_PROD_ID;
            REG_MASK_3:  return mask_rev_in[31:24];
            REG_MASK_2:  return mask_rev_in[23:16];
            REG_MASK_1:  return mask_rev_in[15:8];
            REG_MASK_0:  return mask_rev_in[7:0];
            REG_DCO_ENA: return {7'h00, m_dco};
            REG_BYPASS:  return {7'h00, m_bypass};
            REG_IRQ:     return {7'h00, m_irq};
            REG_RESET:   return {7'h00, m_rst};
            REG_TRAP:    return {7'h00, trap};
            REG_TRIM_0:  return m_trim[7:0];
            REG_TRIM_1:  return m_trim[15:8];
            REG_TRIM_2:  return m_trim[23:16];
            REG_TRIM_3:  return {6'h00, m_trim[25:24]};
            REG_PLL_SEL: return {5'h00, m_sel};
            REG_PLL_DIV: return {3'h0, m_div};
            // Status and unmapped space
            default:     return 8'h00;
        endcase
    endfunction

    // Truncate to register width, read-only addresses ignored
    task automatic model_write(input logic [7:0] addr, input logic [7:0] d);
        case (addr)
            REG_DCO_ENA: m_dco = d[0];
            REG_BYPASS:  m_bypass = d[0];
            REG_IRQ:     m_irq = d[0];
            REG_RESET:   m_rst = d[0];
            REG_TRIM_0:  m_trim[7:0] = d;
            REG_TRIM_1:  m_trim[15:8] = d;
            REG_TRIM_2:  m_trim[23:16] = d;
            REG_TRIM_3:  m_trim[25:24] = d[1:0];
            REG_PLL_SEL: m_sel = d[2:0];
            REG_PLL_DIV: m_div = d[4:0];
            default: ;
        endcase
    endtask

    task automatic check(input string name, input logic [35:0] exp, input logic [35:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_outputs(input string name);
        check({name, " pll"}, {m_dco, m_bypass, m_trim, m_sel, m_div}, pll);
        check({name, " irq"}, 36'(m_irq), 36'(irq));
        check({name, " reset"}, 36'(m_rst), 36'(reset));
    endtask

    // ------------------------------
    // SPI frames
    // ------------------------------

    // Drive each bit on a rising edge, DUT samples it on the next one
    task automatic shift_byte(input logic [7:0] din, output logic [7:0] dout);
        for (int i = 7; i >= 0; i--) begin
            SDI <= din[i];
            @(posedge SCK);
            // SDO moved on the falling edge, stable here
            dout[i] = SDO;
        end
    endtask

    task automatic frame_start();
        @(posedge SCK);
        CSB <= 1'b0;
    endtask

    task automatic frame_end();
        @(posedge SCK);
        CSB <= 1'b1;
        SDI <= 1'b0;
        @(posedge SCK);
    endtask

    task automatic send_header(input logic [7:0] cmd, input logic [7:0] addr);
        logic [7:0] junk;
        shift_byte(cmd, junk);
        shift_byte(addr, junk);
    endtask

    // Data bytes from address a, read value taken before the model write
    task automatic data_bytes(input logic w, input logic rd, input int start, input int cnt,
                              input string name);
        logic [7:0] d;
        logic [7:0] got;
        logic [7:0] exp;
        for (int i = 0; i < cnt; i++) begin
            d = rand_byte();
            exp = model_read(8'(start + i));
            shift_byte(d, got);
            if (rd) begin
                check(name, 36'(exp), 36'(got));
            end
            // Output enable low only while reading
            check({name, " sdo_enb"}, 36'(!rd), 36'(sdo_enb));
            if (w) begin
                model_write(8'(start + i), d);
            end
        end
    endtask

    task automatic read_all(input string name);
        frame_start();
        send_header(make_cmd(1'b0, 1'b1, 3'd0, 1'b0, 1'b0), 8'h00);
        data_bytes(1'b0, 1'b1, 0, 19, name);
        frame_end();
    endtask

    task automatic write_one(input logic [7:0] addr, input logic [7:0] d);
        logic [7:0] junk;
        frame_start();
        send_header(make_cmd(1'b1, 1'b0, 3'd1, 1'b0, 1'b0), addr);
        shift_byte(d, junk);
        model_write(addr, d);
        frame_end();
    endtask

    // ------------------------------
    // Pass-through helpers
    // ------------------------------

    // 0 pass reset, 1/2 mgmt/user csb low, 3/4 mgmt/user sck forwarded
    function automatic logic level_of(input int sel);
        case (sel)
            0:       return pass_thru_reset;
            1:       return !mgmt_flash.csb;
            2:       return !user_flash.csb;
            3:       return mgmt_flash.sck;
            default: return user_flash.sck;
        endcase
    endfunction

    // Poll away from the clock edges
    task automatic wait_level(input int sel, input string what);
        int cnt;
        cnt = 0;
        #2;
        while (!level_of(sel) && cnt < 20) begin
            @(posedge SCK);
            #2;
            cnt++;
        end
        assert (level_of(sel)) else begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s", cnt, what);
        end
    endtask

    task automatic check_forward(input logic to_mgmt, input string name);
        logic [31:0] bits;
        for (int i = 0; i < 8; i++) begin
            @(posedge SCK);
            bits = $urandom;
            SDI <= bits[0];
            mgmt_sdo <= bits[1];
            user_sdo <= bits[2];
            #2;
            check({name, " sck"}, 36'(1'b1),
                  36'(to_mgmt ? mgmt_flash.sck : user_flash.sck));
            @(negedge SCK);
            check({name, " sdi"}, 36'(bits[0]),
                  36'(to_mgmt ? mgmt_flash.sdi : user_flash.sdi));
            check({name, " SDO"}, 36'(to_mgmt ? bits[1] : bits[2]), 36'(SDO));
            check({name, " sdo_enb"}, 36'(1'b0), 36'(sdo_enb));
            check({name, " csb"}, 36'(1'b0), 36'(to_mgmt ? mgmt_flash.csb : user_flash.csb));
            check({name, " idle csb"}, 36'(1'b1),
                  36'(to_mgmt ? user_flash.csb : mgmt_flash.csb));
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        void'($urandom(32'he703_4ceb));
        checks = 0;
        errors = 0;
        timeouts = 0;
        r = $urandom;
        RSTB <= 1'b0;
        CSB <= 1'b1;
        SDI <= 1'b0;
        trap <= r[0];
        mask_rev_in <= $urandom;
        mgmt_sdo <= 1'b0;
        user_sdo <= 1'b0;
        m_dco = `HK_DCO_ENA_RST;
        m_bypass = `HK_BYPASS_RST;
        m_irq = 1'b0;
        m_rst = 1'b0;
        m_trim = `HK_PLL_TRIM_RST;
        m_sel = `HK_PLL_SEL_RST;
        m_div = `HK_PLL_DIV_RST;
        repeat (4) @(posedge SCK);
        RSTB <= 1'b1;
        @(posedge SCK);

        // Idle levels and reset readback
        check("idle sdo_enb", 36'(1'b1), 36'(sdo_enb));
        check("idle SDO", 36'(1'b0), 36'(SDO));
        check("idle mgmt flash", 36'(3'b100), 36'(mgmt_flash));
        check("idle user flash", 36'(3'b100), 36'(user_flash));
        check("idle pass reset", 36'(1'b0), 36'(pass_thru_reset));
        check_outputs("reset");
        read_all("reset readback");

        // Random writes, fixed count or streaming
        repeat (12) begin
            a = $urandom_range(18, 0);
            n = $urandom_range(7, 0);
            len = (n == 0) ? $urandom_range(4, 1) : n;
            frame_start();
            send_header(make_cmd(1'b1, 1'b0, 3'(n), 1'b0, 1'b0), 8'(a));
            data_bytes(1'b1, 1'b0, a, len, "random write");
            frame_end();
            r = $urandom;
            trap <= r[0];
            check_outputs("random write");
            read_all("random write readback");
        end

        // Fixed count, then a second command in the same frame
        repeat (4) begin
            n = $urandom_range(7, 1);
            a = $urandom_range(19 - n, 8);
            frame_start();
            send_header(make_cmd(1'b1, 1'b0, 3'(n), 1'b0, 1'b0), 8'(a));
            data_bytes(1'b1, 1'b0, a, n, "fixed write");
            send_header(make_cmd(1'b0, 1'b1, 3'd0, 1'b0, 1'b0), 8'(a));
            data_bytes(1'b0, 1'b1, a, n + 1, "fixed count");
            frame_end();
            check_outputs("fixed count");
        end

        // Read/write returns the old value
        repeat (6) begin
            a = $urandom_range(18, 0);
            len = $urandom_range(6, 1);
            frame_start();
            send_header(make_cmd(1'b1, 1'b1, 3'd0, 1'b0, 1'b0), 8'(a));
            data_bytes(1'b1, 1'b1, a, len, "read/write");
            frame_end();
            check_outputs("read/write");
        end
        read_all("read/write readback");

        // Management flash pass-through, core reset held only by the pass request
        write_one(REG_RESET, 8'h00);
        frame_start();
        send_header(make_cmd(1'b0, 1'b0, 3'd0, 1'b1, 1'b0), 8'h00);
        wait_level(0, "pass-through reset");
        check("mgmt pass reset", 36'(1'b1), 36'(reset));
        wait_level(1, "mgmt flash csb");
        wait_level(3, "mgmt flash sck");
        check_forward(1'b1, "mgmt pass");
        frame_end();
        check_outputs("after mgmt pass");

        // User flash needs the core held in reset by register
        write_one(REG_RESET, 8'h01);
        frame_start();
        send_header(make_cmd(1'b0, 1'b0, 3'd0, 1'b0, 1'b1), 8'h00);
        wait_level(2, "user flash csb");
        wait_level(4, "user flash sck");
        check("user pass reset", 36'(1'b1), 36'(reset));
        check("user pass_thru_reset", 36'(1'b0), 36'(pass_thru_reset));
        check_forward(1'b0, "user pass");
        frame_end();
        read_all("core reset readback");
        write_one(REG_RESET, 8'h00);
        check_outputs("core reset release");

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: housekeeping_spi.f
+incdir+design
design/hk_pkg.sv
design/hk_spi_slave.sv
design/hk_regfile.sv
design/hk_pass_thru.sv
design/housekeeping_spi.sv
test/tb_housekeeping_spi.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the housekeeping SPI testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f housekeeping_spi.f \
    --top-module tb_housekeeping_spi --Mdir "$BUILD_DIR" -o sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

"$BUILD_DIR/sim" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$SIM_LOG"; then
    exit 0
fi
exit 1
